//--- rtl/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Data RAM geometry and timing
`define RAM_WORDS 64
`define MEM_WAIT 2

// ALU operation codes
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR 3'd3
`define ALU_XOR 3'd4
`define ALU_SLT 3'd5
`define ALU_SLL 3'd6
`define ALU_SRL 3'd7

// Access size in lsType[1:0]
`define LS_BYTE 2'd0
`define LS_HALF 2'd1
`define LS_WORD 2'd2

// MIPS Cause exception codes
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_OV 5'd12

`endif

//--- rtl/mipsPkg.sv
`include "mips_consts.svh"

package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regIdx_t;
    typedef logic [2:0] aluOp_t;

    // Bits 1:0 size, bit 2 unsigned load
    typedef logic [2:0] lsType_t;

    typedef logic [4:0] excCode_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } accessState_t;

    // True when the address does not fit the access size
    function automatic logic misaligned(word_t addr, lsType_t lsType);
        logic bad;
        case (lsType[1:0])
            `LS_BYTE: bad = 1'b0;
            `LS_HALF: bad = addr[0];
            default: bad = (addr[1:0] != 2'b00);
        endcase
        return bad;
    endfunction

endpackage

//--- rtl/exMemIf.sv
interface exMemIf
    import mipsPkg::*;
();

    logic valid;
    word_t aluOut;
    word_t rtValue;
    regIdx_t destReg;
    logic regWrite;
    logic memRead;
    logic memWrite;
    lsType_t lsType;
    logic overflow;

    modport producer (
        output valid,
        output aluOut,
        output rtValue,
        output destReg,
        output regWrite,
        output memRead,
        output memWrite,
        output lsType,
        output overflow
    );

    modport consumer (
        input valid,
        input aluOut,
        input rtValue,
        input destReg,
        input regWrite,
        input memRead,
        input memWrite,
        input lsType,
        input overflow
    );

endinterface

//--- rtl/execUnit.sv
`include "mips_consts.svh"

module execUnit
    import mipsPkg::*;
(
    input aluOp_t aluOp,
    input word_t srcA,
    input word_t srcB,
    input word_t rtValue,
    input regIdx_t destReg,
    input logic inValid,
    input logic regWrite,
    input logic memRead,
    input logic memWrite,
    input lsType_t lsType,
    exMemIf.producer stageE
);

    word_t result;
    logic ovf;

    always_comb begin
        result = '0;
        ovf = 1'b0;
        case (aluOp)
            `ALU_ADD: begin
                result = srcA + srcB;
                // Same-sign operands, result sign flipped
                ovf = (srcA[31] == srcB[31]) && (result[31] != srcA[31]);
            end
            `ALU_SUB: begin
                result = srcA - srcB;
                ovf = (srcA[31] != srcB[31]) && (result[31] != srcA[31]);
            end
            `ALU_AND: begin
                result = srcA & srcB;
            end
            `ALU_OR: begin
                result = srcA | srcB;
            end
            `ALU_XOR: begin
                result = srcA ^ srcB;
            end
            `ALU_SLT: begin
                result = {31'b0, ($signed(srcA) < $signed(srcB))};
            end
            `ALU_SLL: begin
                result = srcA << srcB[4:0];
            end
            `ALU_SRL: begin
                result = srcA >> srcB[4:0];
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // For loads and stores the result is the effective address
    assign stageE.valid = inValid;
    assign stageE.aluOut = result;
    assign stageE.rtValue = rtValue;
    assign stageE.destReg = destReg;
    assign stageE.regWrite = regWrite;
    assign stageE.memRead = memRead;
    assign stageE.memWrite = memWrite;
    assign stageE.lsType = lsType;

    // Address arithmetic never traps
    assign stageE.overflow = ovf && !(memRead || memWrite);

endmodule

//--- rtl/exMemReg.sv
module exMemReg (
    input logic clk,
    input logic rstN,
    input logic flushM,
    input logic stallM,
    exMemIf.consumer stageE,
    exMemIf.producer stageM
);

    logic validQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
            stageM.aluOut <= '0;
            stageM.rtValue <= '0;
            stageM.destReg <= '0;
            stageM.regWrite <= 1'b0;
            stageM.memRead <= 1'b0;
            stageM.memWrite <= 1'b0;
            stageM.lsType <= '0;
            stageM.overflow <= 1'b0;
        end else if (flushM) begin
            validQ <= 1'b0;
            stageM.aluOut <= '0;
            stageM.rtValue <= '0;
            stageM.destReg <= '0;
            stageM.regWrite <= 1'b0;
            stageM.memRead <= 1'b0;
            stageM.memWrite <= 1'b0;
            stageM.lsType <= '0;
            stageM.overflow <= 1'b0;
        end else if (!stallM) begin
            validQ <= stageE.valid;
            stageM.aluOut <= stageE.aluOut;
            stageM.rtValue <= stageE.rtValue;
            stageM.destReg <= stageE.destReg;
            stageM.regWrite <= stageE.regWrite;
            stageM.memRead <= stageE.memRead;
            stageM.memWrite <= stageE.memWrite;
            stageM.lsType <= stageE.lsType;
            stageM.overflow <= stageE.overflow;
        end
    end

    // A flush also squashes the instruction already sitting in M
    assign stageM.valid = validQ && !flushM;

    assert property (@(posedge clk) disable iff (!rstN)
        stallM && !flushM |=> $stable({validQ, stageM.aluOut, stageM.rtValue,
            stageM.destReg, stageM.regWrite, stageM.memRead, stageM.memWrite,
            stageM.lsType, stageM.overflow}))
    else $error("EX/MEM contents changed during a stall");

endmodule

//--- rtl/memWaitTimer.sv
`include "mips_consts.svh"

module memWaitTimer (
    input logic clk,
    input logic rstN,
    input logic timerStart,
    output logic timerDone
);

    localparam int CntW = $clog2(`MEM_WAIT + 1);

    logic [CntW-1:0] count;
    logic armed;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            armed <= 1'b0;
        end else if (timerStart) begin
            // Zero is reached MEM_WAIT cycles after the start
            count <= CntW'(`MEM_WAIT - 1);
            armed <= 1'b1;
        end else if (armed) begin
            if (count == '0) begin
                armed <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign timerDone = armed && (count == '0);

endmodule

//--- rtl/memAccessFsm.sv
`include "mips_consts.svh"

module memAccessFsm
    import mipsPkg::*;
(
    input logic clk,
    input logic rstN,
    input logic flushM,
    exMemIf.consumer stageM,
    input logic timerDone,
    output logic stallM,
    output logic timerStart,
    output logic accessDone
);

    accessState_t state;
    accessState_t nextState;
    logic memOp;
    logic startAccess;

    // Misaligned ops trap in the load/store unit and never reach the RAM
    assign memOp = stageM.valid && (stageM.memRead || stageM.memWrite)
        && !misaligned(stageM.aluOut, stageM.lsType);
    assign startAccess = (state == IDLE) && memOp && !flushM;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: if (startAccess) nextState = WAIT;
            WAIT: if (timerDone) nextState = DONE;
            DONE: nextState = IDLE;
            default: nextState = IDLE;
        endcase
        if (flushM) begin
            nextState = IDLE;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Hold the op in M from the start cycle until the RAM answers
    assign stallM = startAccess || (state == WAIT);
    assign timerStart = startAccess;
    assign accessDone = (state == DONE);

    assert property (@(posedge clk) disable iff (!rstN || flushM)
        timerStart |-> ##(`MEM_WAIT + 1) (accessDone && !stallM))
    else $error("RAM access did not complete after the wait");

endmodule

//--- rtl/loadStoreUnit.sv
`include "mips_consts.svh"

module loadStoreUnit
    import mipsPkg::*;
(
    input logic clk,
    input logic rstN,
    exMemIf.consumer stageM,
    input logic accessDone,
    output logic wbValid,
    output regIdx_t wbReg,
    output word_t wbData,
    output logic excValid,
    output excCode_t excCode,
    output word_t badVAddr
);

    localparam int IdxW = $clog2(`RAM_WORDS);

    word_t ram [`RAM_WORDS];

    logic [IdxW-1:0] wordIdx;
    logic [1:0] byteOff;
    word_t ramWord;
    word_t storeWord;
    word_t loadData;
    logic [7:0] loadByte;
    logic [15:0] loadHalf;
    logic isMem;
    logic badAddr;
    logic aluWb;
    logic loadWb;
    logic doStore;
    logic excHit;

    assign wordIdx = stageM.aluOut[IdxW+1:2];
    assign byteOff = stageM.aluOut[1:0];
    assign ramWord = ram[wordIdx];

    assign isMem = stageM.memRead || stageM.memWrite;
    assign badAddr = misaligned(stageM.aluOut, stageM.lsType);

    // Little-endian lane selection
    assign loadByte = ramWord[{byteOff, 3'b000} +: 8];
    assign loadHalf = ramWord[{byteOff[1], 4'b0000} +: 16];

    always_comb begin
        storeWord = ramWord;
        case (stageM.lsType[1:0])
            `LS_BYTE: storeWord[{byteOff, 3'b000} +: 8] = stageM.rtValue[7:0];
            `LS_HALF: storeWord[{byteOff[1], 4'b0000} +: 16] = stageM.rtValue[15:0];
            default: storeWord = stageM.rtValue;
        endcase
    end

    always_comb begin
        case (stageM.lsType[1:0])
            `LS_BYTE: loadData = {{24{!stageM.lsType[2] && loadByte[7]}}, loadByte};
            `LS_HALF: loadData = {{16{!stageM.lsType[2] && loadHalf[15]}}, loadHalf};
            default: loadData = ramWord;
        endcase
    end

    assign aluWb = stageM.valid && !isMem && !stageM.overflow && stageM.regWrite;
    assign loadWb = accessDone && stageM.valid && stageM.memRead && stageM.regWrite;
    assign doStore = accessDone && stageM.valid && stageM.memWrite;
    assign excHit = stageM.valid && (stageM.overflow || (isMem && badAddr));

    always_ff @(posedge clk) begin
        if (doStore) begin
            ram[wordIdx] <= storeWord;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            excValid <= 1'b0;
        end else begin
            wbValid <= aluWb || loadWb;
            excValid <= excHit;
        end
    end

    always_ff @(posedge clk) begin
        if (aluWb || loadWb) begin
            wbReg <= stageM.destReg;
            wbData <= loadWb ? loadData : stageM.aluOut;
        end
        if (excHit) begin
            if (stageM.overflow) begin
                excCode <= `EXC_OV;
                badVAddr <= '0;
            end else begin
                excCode <= stageM.memWrite ? `EXC_ADES : `EXC_ADEL;
                badVAddr <= stageM.aluOut;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        stageM.valid |-> !(stageM.memRead && stageM.memWrite))
    else $error("Bundle is both a load and a store");

endmodule

//--- rtl/memBackend.sv
module memBackend
    import mipsPkg::*;
(
    input logic clk,
    input logic rstN,
    input logic inValid,
    input logic flushM,
    input aluOp_t aluOp,
    input word_t srcA,
    input word_t srcB,
    input word_t rtValue,
    input regIdx_t destReg,
    input logic regWrite,
    input logic memRead,
    input logic memWrite,
    input lsType_t lsType,
    output logic busy,
    output logic wbValid,
    output regIdx_t wbReg,
    output word_t wbData,
    output logic excValid,
    output excCode_t excCode,
    output word_t badVAddr
);

    exMemIf stageE ();
    exMemIf stageM ();

    logic stallM;
    logic timerStart;
    logic timerDone;
    logic accessDone;

    assign busy = stallM;

    execUnit uExec (
        .aluOp(aluOp),
        .srcA(srcA),
        .srcB(srcB),
        .rtValue(rtValue),
        .destReg(destReg),
        .inValid(inValid),
        .regWrite(regWrite),
        .memRead(memRead),
        .memWrite(memWrite),
        .lsType(lsType),
        .stageE(stageE.producer)
    );

    exMemReg uExMem (
        .clk(clk),
        .rstN(rstN),
        .flushM(flushM),
        .stallM(stallM),
        .stageE(stageE.consumer),
        .stageM(stageM.producer)
    );

    memAccessFsm uFsm (
        .clk(clk),
        .rstN(rstN),
        .flushM(flushM),
        .stageM(stageM.consumer),
        .timerDone(timerDone),
        .stallM(stallM),
        .timerStart(timerStart),
        .accessDone(accessDone)
    );

    memWaitTimer uTimer (
        .clk(clk),
        .rstN(rstN),
        .timerStart(timerStart),
        .timerDone(timerDone)
    );

    loadStoreUnit uLsu (
        .clk(clk),
        .rstN(rstN),
        .stageM(stageM.consumer),
        .accessDone(accessDone),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData),
        .excValid(excValid),
        .excCode(excCode),
        .badVAddr(badVAddr)
    );

endmodule

//--- sim/tbMemBackend.sv
`include "mips_consts.svh"

module tbMemBackend
    import mipsPkg::*;
();

    typedef struct packed {
        logic isExc;
        regIdx_t rd;
        word_t data;
        excCode_t code;
    } result_t;

    localparam int Limit = 40;
    localparam lsType_t LsByte = {1'b0, `LS_BYTE};
    localparam lsType_t LsByteU = {1'b1, `LS_BYTE};
    localparam lsType_t LsHalf = {1'b0, `LS_HALF};
    localparam lsType_t LsHalfU = {1'b1, `LS_HALF};
    localparam lsType_t LsWord = {1'b0, `LS_WORD};

    logic clk = 1'b0;
    logic rstN;
    logic inValid;
    logic flushM;
    aluOp_t aluOp;
    word_t srcA;
    word_t srcB;
    word_t rtValue;
    regIdx_t destReg;
    logic regWrite;
    logic memRead;
    logic memWrite;
    lsType_t lsType;
    logic busy;
    logic wbValid;
    regIdx_t wbReg;
    word_t wbData;
    logic excValid;
    excCode_t excCode;
    word_t badVAddr;

    word_t seed = 32'h1b8c;
    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int issueCycle = 0;
    int doneCycle = 0;
    int busyCycles = 0;
    string curTest = "reset";
    result_t expQ[$];
    result_t head;
    // Byte-wide shadow of the data RAM
    logic [7:0] shadowMem [256];

    memBackend UUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic checkValue(string what, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s %s: expected %h actual %h", curTest, what, expected, actual);
        end
    endtask

    // Results leave the DUT in issue order
    always @(negedge clk) begin
        if (busy) begin
            busyCycles++;
        end
        if (rstN && (wbValid || excValid)) begin
            doneCycle = cycle;
            if (expQ.size() == 0) begin
                errors++;
                $display("Unexpected result in %s: wbValid %b excValid %b",
                    curTest, wbValid, excValid);
            end else begin
                head = expQ.pop_front();
                checkValue("wbValid", word_t'(!head.isExc), word_t'(wbValid));
                checkValue("excValid", word_t'(head.isExc), word_t'(excValid));
                if (head.isExc) begin
                    checkValue("excCode", word_t'(head.code), word_t'(excCode));
                    checkValue("badVAddr", head.data, badVAddr);
                end else begin
                    checkValue("wbReg", word_t'(head.rd), word_t'(wbReg));
                    checkValue("wbData", head.data, wbData);
                end
            end
        end
    end

    function automatic word_t nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic word_t aluModel(aluOp_t op, word_t a, word_t b);
        case (op)
            `ALU_ADD: return a + b;
            `ALU_SUB: return a - b;
            `ALU_AND: return a & b;
            `ALU_OR: return a | b;
            `ALU_XOR: return a ^ b;
            `ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `ALU_SLL: return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    // Wide sum that does not fit back into 32 signed bits
    function automatic logic overflows(aluOp_t op, word_t a, word_t b);
        longint s;
        word_t lo;
        if (op == `ALU_ADD) begin
            s = longint'($signed(a)) + longint'($signed(b));
        end else if (op == `ALU_SUB) begin
            s = longint'($signed(a)) - longint'($signed(b));
        end else begin
            return 1'b0;
        end
        lo = s[31:0];
        return s != longint'($signed(lo));
    endfunction

    function automatic logic misalignedModel(word_t addr, lsType_t ls);
        int bytes;
        bytes = 1 << ls[1:0];
        return (addr % bytes) != 0;
    endfunction

    task automatic shadowStore(word_t addr, lsType_t ls, word_t data);
        for (int i = 0; i < (1 << ls[1:0]); i++) begin
            shadowMem[addr[7:0] + 8'(i)] = data[8*i +: 8];
        end
    endtask

    function automatic word_t shadowLoad(word_t addr, lsType_t ls);
        word_t v;
        int n;
        v = '0;
        n = 1 << ls[1:0];
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = shadowMem[addr[7:0] + 8'(i)];
        end
        if (!ls[2] && v[8*n-1]) begin
            for (int i = n; i < 4; i++) begin
                v[8*i +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    task automatic expectWb(regIdx_t rd, word_t data);
        expQ.push_back(result_t'{1'b0, rd, data, 5'd0});
    endtask

    task automatic expectExc(excCode_t code, word_t addr);
        expQ.push_back(result_t'{1'b1, 5'd0, addr, code});
    endtask

    // Waits for busy low, presents one instruction for one cycle
    task automatic issue(aluOp_t op, word_t a, word_t b, word_t rt, regIdx_t rd,
                         logic rw, logic mr, logic mw, lsType_t ls);
        int n;
        n = 0;
        while (busy && n < Limit) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            errors++;
            $display("Timeout in %s: busy never dropped", curTest);
        end
        aluOp = op;
        srcA = a;
        srcB = b;
        rtValue = rt;
        destReg = rd;
        regWrite = rw;
        memRead = mr;
        memWrite = mw;
        lsType = ls;
        inValid = 1'b1;
        issueCycle = cycle;
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        @(negedge clk);
        while ((expQ.size() != 0 || busy) && n < Limit) begin
            @(negedge clk);
            n++;
        end
        if (expQ.size() != 0 || busy) begin
            errors++;
            $display("Timeout in %s: %0d results still missing", curTest, expQ.size());
            expQ.delete();
        end
    endtask

    task automatic runAlu(aluOp_t op, word_t a, word_t b, regIdx_t rd);
        if (overflows(op, a, b)) begin
            expectExc(`EXC_OV, 32'd0);
        end else begin
            expectWb(rd, aluModel(op, a, b));
        end
        issue(op, a, b, 32'd0, rd, 1'b1, 1'b0, 1'b0, 3'd0);
    endtask

    // Effective address is addr + 0 through the ALU
    task automatic memOp(logic isStore, lsType_t ls, word_t addr, regIdx_t rd);
        word_t rt;
        rt = nextRand();
        if (misalignedModel(addr, ls)) begin
            expectExc(isStore ? `EXC_ADES : `EXC_ADEL, addr);
        end else if (isStore) begin
            shadowStore(addr, ls, rt);
        end else begin
            expectWb(rd, shadowLoad(addr, ls));
        end
        issue(`ALU_ADD, addr, 32'd0, rt, rd, !isStore, !isStore, isStore, ls);
    endtask

    task automatic memChecked(logic isStore, lsType_t ls, word_t addr, regIdx_t rd);
        logic bad;
        bad = misalignedModel(addr, ls);
        busyCycles = 0;
        memOp(isStore, ls, addr, rd);
        waitDrain();
        checkValue("busy cycles", bad ? 32'd0 : `MEM_WAIT + 1, busyCycles);
        if (bad) begin
            checkValue("latency", 32'd2, doneCycle - issueCycle);
        end else if (!isStore) begin
            checkValue("latency", 2 + `MEM_WAIT + 1, doneCycle - issueCycle);
        end
    endtask

    task automatic sweepAluOps();
        aluOp_t op;
        word_t a;
        word_t b;
        curTest = "alu";
        for (int rep = 0; rep < 3; rep++) begin
            for (int k = 0; k < 8; k++) begin
                op = aluOp_t'(k);
                a = nextRand();
                b = nextRand();
                if (op == `ALU_ADD || op == `ALU_SUB) begin
                    a = a >> 2;
                    b = b >> 2;
                end
                runAlu(op, a, b, regIdx_t'(nextRand()));
                waitDrain();
                checkValue("latency", 32'd2, doneCycle - issueCycle);
            end
        end
    endtask

    task automatic overflowTraps();
        curTest = "overflow";
        runAlu(`ALU_ADD, 32'h6000_0000, 32'h5000_0000, 5'd3);
        runAlu(`ALU_SUB, 32'h8000_0000, 32'h0000_0001, 5'd4);
        runAlu(`ALU_ADD, 32'd5, 32'd7, 5'd5);
        waitDrain();
    endtask

    task automatic storeLoadPairs();
        curTest = "loadstore";
        memChecked(1'b1, LsWord, 32'h40, 5'd0);
        memChecked(1'b0, LsWord, 32'h40, 5'd6);
        memChecked(1'b1, LsHalf, 32'h42, 5'd0);
        memChecked(1'b0, LsHalf, 32'h42, 5'd7);
        memChecked(1'b0, LsHalfU, 32'h42, 5'd8);
        memChecked(1'b1, LsByte, 32'h41, 5'd0);
        memChecked(1'b0, LsByte, 32'h41, 5'd9);
        memChecked(1'b0, LsByteU, 32'h41, 5'd10);
        memChecked(1'b0, LsWord, 32'h40, 5'd11);
        memChecked(1'b1, LsWord, 32'h44, 5'd0);
        memChecked(1'b1, LsHalf, 32'h46, 5'd0);
        memChecked(1'b0, LsByte, 32'h47, 5'd12);
        memChecked(1'b0, LsHalfU, 32'h46, 5'd13);
    endtask

    task automatic addressErrors();
        curTest = "addrerr";
        memChecked(1'b0, LsHalf, 32'h49, 5'd14);
        memChecked(1'b1, LsWord, 32'h46, 5'd0);
        memChecked(1'b0, LsWord, 32'h44, 5'd15);
    endtask

    task automatic backToBack();
        curTest = "backpressure";
        memOp(1'b1, LsWord, 32'h50, 5'd0);
        memOp(1'b0, LsWord, 32'h50, 5'd16);
        runAlu(`ALU_ADD, nextRand() >> 2, nextRand() >> 2, 5'd17);
        memOp(1'b0, LsByteU, 32'h51, 5'd18);
        runAlu(`ALU_XOR, nextRand(), nextRand(), 5'd19);
        memOp(1'b1, LsHalf, 32'h52, 5'd0);
        memOp(1'b0, LsHalf, 32'h52, 5'd20);
        waitDrain();
    endtask

    task automatic flushSquash();
        curTest = "flush";
        issue(`ALU_OR, nextRand(), nextRand(), 32'd0, 5'd21, 1'b1, 1'b0, 1'b0, 3'd0);
        flushM = 1'b1;
        @(negedge clk);
        flushM = 1'b0;
        // Any result here is reported as unexpected
        repeat (Limit) @(negedge clk);
        runAlu(`ALU_SUB, 32'd100, 32'd58, 5'd22);
        waitDrain();
    endtask

    initial begin
        rstN = 1'b0;
        inValid = 1'b0;
        flushM = 1'b0;
        aluOp = '0;
        srcA = '0;
        srcB = '0;
        rtValue = '0;
        destReg = '0;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        lsType = '0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkValue("busy", 32'd0, word_t'(busy));
        checkValue("wbValid", 32'd0, word_t'(wbValid));
        checkValue("excValid", 32'd0, word_t'(excValid));
        sweepAluOps();
        overflowTraps();
        storeLoadPairs();
        addressErrors();
        backToBack();
        flushSquash();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #100000;
        $display("Watchdog expired in test %s", curTest);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/exMemIf.sv
rtl/execUnit.sv
rtl/exMemReg.sv
rtl/memWaitTimer.sv
rtl/memAccessFsm.sv
rtl/loadStoreUnit.sv
rtl/memBackend.sv
sim/tbMemBackend.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tbMemBackend
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_MSG ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
